/* itlb.f */
+incdir+.
vm_pkg.sv
itlb_pkg.sv
itlb_entries.sv
itlb_ctrl.sv
itlb_fill.sv
itlb.sv
tb_itlb_chk.sv
tb_itlb_mon.sv
tb_itlb.sv

/* itlb.sv */
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // System
  input  logic                  vmem_on_i,
  input  vm_pkg::asid_t         cur_asid_i,
  input  itlb_pkg::flush_req_t  flush_i,
  // Cache request and answer
  input  logic                  icache_req_valid_i,
  input  itlb_pkg::icache_req_t icache_req_i,
  output logic                  icache_req_rdy_o,
  output logic                  icache_ans_valid_o,
  output itlb_pkg::icache_ans_t icache_ans_o,
  // L2 request and answer
  output logic                  l2c_req_valid_o,
  output itlb_pkg::l2c_req_t    l2c_req_o,
  input  logic                  l2c_req_rdy_i,
  input  logic                  l2c_ans_valid_i,
  input  itlb_pkg::l2c_ans_t    l2c_ans_i
);

  vm_pkg::tlb_entry_t       entries [`ITLB_ENTRIES];
  logic                     hit;
  vm_pkg::ppn_t             hit_ppn;
  logic                     hit_exec;
  logic                     flush;
  logic [`ITLB_ENTRIES-1:0] flush_vec;
  logic                     replace;
  logic                     exc_reg_en;
  logic                     exc_reg_clr;
  logic                     tlb_cond_ready;
  logic                     waiting_l2c_ans;
  itlb_pkg::exception_e     itlb_exception;

  // Lookup and storage
  itlb_entries i_entries (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .vmem_on_i    (vmem_on_i),
    .cur_asid_i   (cur_asid_i),
    .lookup_vpn_i (icache_req_i.vpn),
    .flush_i      (flush),
    .flush_vec_i  (flush_vec),
    .replace_i    (replace),
    .fill_i       (l2c_ans_i),
    .fill_vpn_i   (icache_req_i.vpn),
    .entries_o    (entries),
    .hit_o        (hit),
    .hit_ppn_o    (hit_ppn),
    .hit_exec_o   (hit_exec)
  );

  // Flush and flow control
  itlb_ctrl i_ctrl (
    .vmem_on_i           (vmem_on_i),
    .tlb_cond_ready_i    (tlb_cond_ready),
    .waiting_l2c_ans_i   (waiting_l2c_ans),
    .flush_i             (flush_i),
    .entries_i           (entries),
    .icache_req_valid_i  (icache_req_valid_i),
    .itlb_hit_i          (hit),
    .itlb_exception_i    (itlb_exception),
    .l2c_ans_valid_i     (l2c_ans_valid_i),
    .l2c_ans_exception_i (l2c_ans_i.exception),
    .flush_o             (flush),
    .flush_vec_o         (flush_vec),
    .icache_req_rdy_o    (icache_req_rdy_o),
    .icache_ans_valid_o  (icache_ans_valid_o),
    .exception_reg_en_o  (exc_reg_en),
    .exception_reg_clr_o (exc_reg_clr),
    .replace_o           (replace)
  );

  // Miss handling and answer
  itlb_fill i_fill (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .flush_i             (flush_i),
    .icache_req_valid_i  (icache_req_valid_i),
    .req_vpn_i           (icache_req_i.vpn),
    .cur_asid_i          (cur_asid_i),
    .itlb_hit_i          (hit),
    .icache_req_rdy_i    (icache_req_rdy_o),
    .hit_ppn_i           (hit_ppn),
    .hit_exec_i          (hit_exec),
    .exception_reg_en_i  (exc_reg_en),
    .exception_reg_clr_i (exc_reg_clr),
    .l2c_req_rdy_i       (l2c_req_rdy_i),
    .l2c_ans_valid_i     (l2c_ans_valid_i),
    .l2c_ans_i           (l2c_ans_i),
    .tlb_cond_ready_o    (tlb_cond_ready),
    .waiting_l2c_ans_o   (waiting_l2c_ans),
    .itlb_exception_o    (itlb_exception),
    .l2c_req_valid_o     (l2c_req_valid_o),
    .l2c_req_o           (l2c_req_o),
    .icache_ans_o        (icache_ans_o)
  );

endmodule

/* itlb_ctrl.sv */
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_ctrl (
  // System
  input  logic                     vmem_on_i,
  // From the miss block
  input  logic                     tlb_cond_ready_i,
  input  logic                     waiting_l2c_ans_i,
  // Flush request
  input  itlb_pkg::flush_req_t     flush_i,
  // Entry view
  input  vm_pkg::tlb_entry_t       entries_i [`ITLB_ENTRIES],
  // Lookup
  input  logic                     icache_req_valid_i,
  input  logic                     itlb_hit_i,
  // Stored fault
  input  itlb_pkg::exception_e     itlb_exception_i,
  // L2 answer
  input  logic                     l2c_ans_valid_i,
  input  itlb_pkg::exception_e     l2c_ans_exception_i,
  // Flush control
  output logic                     flush_o,
  output logic [`ITLB_ENTRIES-1:0] flush_vec_o,
  // Cache flow control
  output logic                     icache_req_rdy_o,
  output logic                     icache_ans_valid_o,
  // Fault register and fill control
  output logic                     exception_reg_en_o,
  output logic                     exception_reg_clr_o,
  output logic                     replace_o
);

  localparam int N = `ITLB_ENTRIES;

  logic l2c_ans_here;

  // Flush select
  always_comb begin
    flush_o     = 1'b0;
    flush_vec_o = '0;
    case (flush_i.ftype)
      // By ASID, global pages survive
      itlb_pkg::FlushASID: begin
        flush_o = 1'b1;
        for (int k = 0; k < N; k++) begin
          flush_vec_o[k] = (entries_i[k].asid == flush_i.opnd.as_asid.asid)
                           && !entries_i[k].glob;
        end
      end
      // By page, each entry compared at its own size
      itlb_pkg::FlushPage: begin
        flush_o = 1'b1;
        for (int k = 0; k < N; k++) begin
          flush_vec_o[k] = vm_pkg::vpn_covers(entries_i[k].vpn, flush_i.opnd.as_vpn,
                                              entries_i[k].size);
        end
      end
      itlb_pkg::FlushAll: begin
        flush_o     = 1'b1;
        flush_vec_o = '1;
      end
      default: begin
        flush_o     = 1'b0;
        flush_vec_o = '0;
      end
    endcase
  end

  // L2 answer while a miss is outstanding
  assign l2c_ans_here = waiting_l2c_ans_i && l2c_ans_valid_i;

  // Flow control
  always_comb begin
    icache_req_rdy_o    = 1'b0;
    icache_ans_valid_o  = 1'b0;
    exception_reg_en_o  = 1'b0;
    exception_reg_clr_o = 1'b0;
    if (tlb_cond_ready_i && !icache_req_valid_i) begin
      // Idle, nothing to serve
      icache_req_rdy_o = 1'b1;
    end else if (tlb_cond_ready_i && icache_req_valid_i) begin
      // Hit or pending fault answers now
      // The fault store is consumed by this answer
      if (itlb_hit_i || (itlb_exception_i != itlb_pkg::NoException)) begin
        exception_reg_clr_o = 1'b1;
        icache_req_rdy_o    = 1'b1;
        icache_ans_valid_o  = 1'b1;
      end
    end else if (l2c_ans_here && vmem_on_i) begin
      // Capture the L2 fault code
      exception_reg_en_o = 1'b1;
    end
  end

  // Install only a fault-free answer, and only with translation on
  assign replace_o = l2c_ans_here && vmem_on_i
                     && (l2c_ans_exception_i == itlb_pkg::NoException);

endmodule

/* itlb_entries.sv */
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_entries (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                vmem_on_i,
  input  vm_pkg::asid_t       cur_asid_i,
  input  vm_pkg::vpn_t        lookup_vpn_i,
  input  logic                flush_i,
  input  logic [`ITLB_ENTRIES-1:0] flush_vec_i,
  input  logic                replace_i,
  input  itlb_pkg::l2c_ans_t  fill_i,
  input  vm_pkg::vpn_t        fill_vpn_i,
  output vm_pkg::tlb_entry_t  entries_o [`ITLB_ENTRIES],
  output logic                hit_o,
  output vm_pkg::ppn_t        hit_ppn_o,
  output logic                hit_exec_o
);

  localparam int N     = `ITLB_ENTRIES;
  localparam int L     = `ITLB_VPN_LVL_W;
  localparam int IDX_W = $clog2(N);

  // Payload array, valid bits kept apart
  vm_pkg::tlb_entry_t entry_q [N];
  logic [N-1:0]       valid_q;
  logic [N-1:0]       match;
  logic [IDX_W-1:0]   rr_q;
  logic [IDX_W-1:0]   victim;
  logic               free_found;
  vm_pkg::ppn_t       sel_ppn;
  logic               sel_exec;

  // Entry view with live valid bits
  always_comb begin
    for (int k = 0; k < N; k++) begin
      entries_o[k]       = entry_q[k];
      entries_o[k].valid = valid_q[k];
    end
  end

  // Tag compare at entry size, ASID ignored for global pages
  always_comb begin
    for (int k = 0; k < N; k++) begin
      match[k] = valid_q[k]
                 && vm_pkg::vpn_covers(entry_q[k].vpn, lookup_vpn_i, entry_q[k].size)
                 && (entry_q[k].glob || (entry_q[k].asid == cur_asid_i));
    end
  end

  // PPN of the hit entry
  always_comb begin
    sel_ppn  = '0;
    sel_exec = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (match[k]) begin
        sel_ppn  = entry_q[k].ppn;
        sel_exec = entry_q[k].exec;
        // Superpages take the low levels from the VPN
        if (entry_q[k].size == vm_pkg::page_1g) begin
          sel_ppn[2*L-1:0] = lookup_vpn_i[1:0];
        end else if (entry_q[k].size == vm_pkg::page_2m) begin
          sel_ppn[L-1:0] = lookup_vpn_i[0];
        end
      end
    end
  end

  // Translation off: always hit, VPN passed through
  assign hit_o      = vmem_on_i ? |match : 1'b1;
  assign hit_ppn_o  = vmem_on_i ? sel_ppn : vm_pkg::ppn_t'(lookup_vpn_i);
  assign hit_exec_o = vmem_on_i ? sel_exec : 1'b1;

  // Victim choice, first invalid slot wins over the pointer
  always_comb begin
    victim     = rr_q;
    free_found = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (!valid_q[k] && !free_found) begin
        victim     = IDX_W'(k);
        free_found = 1'b1;
      end
    end
  end

  // Valid bits and round-robin pointer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= valid_q & ~flush_vec_i;
      end
      // Fill wins over a flush of the same slot
      if (replace_i) begin
        valid_q[victim] <= 1'b1;
        rr_q            <= rr_q + 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (replace_i) begin
      entry_q[victim] <= '{valid: 1'b1, vpn: fill_vpn_i, ppn: fill_i.ppn, asid: cur_asid_i,
                           glob: fill_i.glob, size: fill_i.size, exec: fill_i.exec};
    end
  end

endmodule

/* itlb_fill.sv */
`timescale 1ns/1ps

module itlb_fill (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  itlb_pkg::flush_req_t  flush_i,
  input  logic                  icache_req_valid_i,
  input  vm_pkg::vpn_t          req_vpn_i,
  input  vm_pkg::asid_t         cur_asid_i,
  input  logic                  itlb_hit_i,
  input  logic                  icache_req_rdy_i,
  input  vm_pkg::ppn_t          hit_ppn_i,
  input  logic                  hit_exec_i,
  input  logic                  exception_reg_en_i,
  input  logic                  exception_reg_clr_i,
  input  logic                  l2c_req_rdy_i,
  input  logic                  l2c_ans_valid_i,
  input  itlb_pkg::l2c_ans_t    l2c_ans_i,
  output logic                  tlb_cond_ready_o,
  output logic                  waiting_l2c_ans_o,
  output itlb_pkg::exception_e  itlb_exception_o,
  output logic                  l2c_req_valid_o,
  output itlb_pkg::l2c_req_t    l2c_req_o,
  output itlb_pkg::icache_ans_t icache_ans_o
);

  // Miss FSM
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_e;

  state_e               state_q;
  itlb_pkg::exception_e exc_q;
  logic                 miss;

  // Lookup possible only when idle and no flush this cycle
  assign tlb_cond_ready_o  = (state_q == IDLE) && (flush_i.ftype == itlb_pkg::NoFlush);
  assign waiting_l2c_ans_o = (state_q == WAIT);

  // Valid request left unanswered
  assign miss = tlb_cond_ready_o && icache_req_valid_i && !icache_req_rdy_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (miss) state_q <= REQ;
        // Hold the request until L2 takes it
        REQ:     if (l2c_req_rdy_i) state_q <= WAIT;
        WAIT:    if (l2c_ans_valid_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Fault store, cleared by the answer that reports it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exc_q <= itlb_pkg::NoException;
    end else if (exception_reg_clr_i) begin
      exc_q <= itlb_pkg::NoException;
    end else if (exception_reg_en_i) begin
      exc_q <= l2c_ans_i.exception;
    end
  end

  assign itlb_exception_o = exc_q;

  // Held request is stable, so it feeds L2 directly
  assign l2c_req_valid_o = (state_q == REQ);
  assign l2c_req_o       = '{vpn: req_vpn_i, asid: cur_asid_i};

  // Answer formation
  always_comb begin
    icache_ans_o = '{ppn: hit_ppn_i, exception: itlb_pkg::NoException};
    if (exc_q != itlb_pkg::NoException) begin
      icache_ans_o = '{ppn: '0, exception: exc_q};
    end else if (itlb_hit_i && !hit_exec_i) begin
      // No execute right on the hit page
      icache_ans_o.exception = itlb_pkg::InstrPageFault;
    end
  end

endmodule

/* itlb_params.svh */
`ifndef ITLB_PARAMS_SVH
`define ITLB_PARAMS_SVH

// Number of fully associative entries
`define ITLB_ENTRIES 8

// Address space identifier width
`define ITLB_ASID_W 16

// Bits per VPN level, Sv39 style
`define ITLB_VPN_LVL_W 9

// Physical page number width
`define ITLB_PPN_W 44

`endif

/* itlb_pkg.sv */
package itlb_pkg;

  // Exception codes returned to the cache
  typedef enum logic [1:0] {
    NoException,
    InstrPageFault,
    InstrAccessFault
  } exception_e;

  // Flush kinds, NoFlush is idle
  typedef enum logic [1:0] {
    NoFlush,
    FlushASID,
    FlushPage,
    FlushAll
  } tlb_flush_e;

  // ASID view of the flush operand, padded up to the VPN width
  typedef struct packed {
    logic [$bits(vm_pkg::vpn_t)-$bits(vm_pkg::asid_t)-1:0] rsvd;
    vm_pkg::asid_t                                         asid;
  } flush_asid_t;

  // Flush operand word
  // Read as an ASID for FlushASID, as a VPN for FlushPage
  typedef union packed {
    flush_asid_t  as_asid;
    vm_pkg::vpn_t as_vpn;
  } flush_opnd_u;

  typedef struct packed {
    tlb_flush_e  ftype;
    flush_opnd_u opnd;
  } flush_req_t;

  // Cache side
  typedef struct packed {
    vm_pkg::vpn_t vpn;
  } icache_req_t;

  typedef struct packed {
    vm_pkg::ppn_t ppn;
    exception_e   exception;
  } icache_ans_t;

  // L2 translation side
  typedef struct packed {
    vm_pkg::vpn_t  vpn;
    vm_pkg::asid_t asid;
  } l2c_req_t;

  typedef struct packed {
    vm_pkg::ppn_t       ppn;
    vm_pkg::page_size_e size;
    logic               glob;
    logic               exec;
    exception_e         exception;
  } l2c_ans_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the ITLB testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f itlb.f --top-module tb_itlb -o sim_itlb &&
./obj_dir/sim_itlb | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb_itlb.sv */
`timescale 1ns/1ps

module tb_itlb;

  localparam int RESET_CYC = 10;
  localparam int NUM_REQ   = 40 + 5 + 36 + 24 + 12;
  localparam int NUM_FLUSH = 5;
  localparam int TIMEOUT   = NUM_REQ * 12 + RESET_CYC + NUM_FLUSH * 2;
  localparam int POOL      = 12;

  logic                  clk;
  logic                  arst_n;
  logic                  vmem_on;
  vm_pkg::asid_t         cur_asid;
  itlb_pkg::flush_req_t  flush;
  logic                  req_valid;
  itlb_pkg::icache_req_t req;
  logic                  req_rdy;
  logic                  ans_valid;
  itlb_pkg::icache_ans_t ans;
  logic                  l2_req_valid;
  itlb_pkg::l2c_req_t    l2_req;
  logic                  l2_req_rdy;
  logic                  l2_ans_valid;
  itlb_pkg::l2c_ans_t    l2_ans;

  logic [26:0] pool [POOL];
  int          cycles = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          err_mark = 0;

  itlb i_itlb (
    .clk_i (clk), .arst_n_i (arst_n), .vmem_on_i (vmem_on), .cur_asid_i (cur_asid),
    .flush_i (flush), .icache_req_valid_i (req_valid), .icache_req_i (req),
    .icache_req_rdy_o (req_rdy), .icache_ans_valid_o (ans_valid), .icache_ans_o (ans),
    .l2c_req_valid_o (l2_req_valid), .l2c_req_o (l2_req), .l2c_req_rdy_i (l2_req_rdy),
    .l2c_ans_valid_i (l2_ans_valid), .l2c_ans_i (l2_ans)
  );

  tb_itlb_mon i_mon (
    .clk_i (clk), .arst_n_i (arst_n), .vmem_on_i (vmem_on), .cur_asid_i (cur_asid),
    .flush_i (flush), .icache_req_i (req),
    .icache_ans_valid_o (ans_valid), .icache_ans_o (ans),
    .l2c_req_valid_o (l2_req_valid), .l2c_req_o (l2_req), .l2c_req_rdy_i (l2_req_rdy),
    .l2c_ans_valid_i (l2_ans_valid)
  );

  always #10 clk = ~clk;

  // Cycle limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // L2 ready mostly high with some back-pressure
  always @(posedge clk) begin
    #2 l2_req_rdy = ($urandom % 4) != 0;
  end

  // L2 responder answers after 1 to 6 cycles
  initial begin
    logic [26:0]   v;
    vm_pkg::asid_t a;
    int            dly;
    forever begin
      @(negedge clk);
      if (arst_n && l2_req_valid && l2_req_rdy) begin
        v   = l2_req.vpn;
        a   = l2_req.asid;
        dly = 1 + ($urandom % 6);
        repeat (dly) @(posedge clk);
        #2;
        l2_ans_valid     = 1'b1;
        l2_ans.ppn       = vm_pkg::ppn_t'(v) * 44'd3 + vm_pkg::ppn_t'(a);
        l2_ans.size      = (v[1:0] == 2'd0) ? vm_pkg::page_1g :
                           (v[1:0] == 2'd1) ? vm_pkg::page_2m : vm_pkg::page_4k;
        l2_ans.glob      = v[3];
        l2_ans.exec      = !v[4];
        l2_ans.exception = (v % 13 == 0) ? itlb_pkg::InstrPageFault : itlb_pkg::NoException;
        @(posedge clk);
        #2 l2_ans_valid = 1'b0;
      end
    end
  end

  // Called 2 ns after an edge and returns likewise
  task automatic send_req(input logic [26:0] v);
    req_valid = 1'b1;
    req.vpn   = v;
    do @(negedge clk); while (!ans_valid);
    @(posedge clk);
    #2 req_valid = 1'b0;
  endtask

  task automatic send_flush(input itlb_pkg::tlb_flush_e ft, input logic [26:0] opnd);
    flush.ftype = ft;
    flush.opnd  = opnd;
    @(posedge clk);
    #2 flush.ftype = itlb_pkg::NoFlush;
  endtask

  task automatic pool_pass();
    for (int k = 0; k < POOL; k++) send_req(pool[k]);
  endtask

  // One result line per test
  task automatic close_test(input string name);
    int e;
    e = i_mon.err_count - err_mark;
    err_mark = i_mon.err_count;
    tests++;
    if (e != 0) begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", tests, name, e);
    end else begin
      $display("test %0d %s: passed", tests, name);
    end
  endtask

  initial begin
    void'($urandom(30487));
    clk          = 1'b0;
    arst_n       = 1'b0;
    vmem_on      = 1'b1;
    cur_asid     = 16'd1;
    flush        = '0;
    req_valid    = 1'b0;
    req          = '0;
    l2_req_rdy   = 1'b0;
    l2_ans_valid = 1'b0;
    l2_ans       = '0;
    // Small pool sharing upper levels, so superpages overlap
    for (int k = 0; k < POOL; k++) begin
      pool[k] = {9'($urandom % 2), 9'($urandom % 3), 9'($urandom % 512)};
    end
    repeat (RESET_CYC) @(posedge clk);
    #2 arst_n = 1'b1;

    for (int k = 0; k < 40; k++) send_req(pool[$urandom % POOL]);
    close_test("miss then hit");

    // VPN 26 faults in L2
    // VPN 18 has no exec right
    send_flush(itlb_pkg::FlushAll, '0);
    send_req(27'd26);
    send_req(27'd26);
    send_req(27'd18);
    send_req(27'd18);
    send_req(27'd18);
    close_test("faults");

    send_flush(itlb_pkg::FlushAll, '0);
    pool_pass();
    cur_asid = 16'd2;
    pool_pass();
    cur_asid = 16'd1;
    send_flush(itlb_pkg::FlushASID, 27'd1);
    pool_pass();
    close_test("flush all and flush by asid");

    send_flush(itlb_pkg::FlushPage, pool[$urandom % POOL]);
    pool_pass();
    send_flush(itlb_pkg::FlushPage, pool[$urandom % POOL]);
    pool_pass();
    close_test("flush by page");

    vmem_on = 1'b0;
    for (int k = 0; k < 12; k++) send_req(27'($urandom));
    close_test("virtual memory off");

    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, failed_tests, i_mon.check_count, i_mon.err_count,
             i_itlb.i_itlb_chk.fail_cnt);
    if (failed_tests == 0 && i_mon.err_count == 0 && i_itlb.i_itlb_chk.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb_itlb_chk.sv */
`timescale 1ns/1ps

module tb_itlb_chk (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input itlb_pkg::flush_req_t  flush_i,
  input logic                  icache_req_valid_i,
  input logic                  icache_req_rdy_o,
  input logic                  icache_ans_valid_o,
  input logic                  l2c_req_valid_o,
  input itlb_pkg::l2c_req_t    l2c_req_o,
  input logic                  l2c_req_rdy_i
);

  // Failed assertions so far, read by the testbench verdict
  int fail_cnt = 0;

  // An answer only goes with an accepted request
  ans_needs_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    icache_ans_valid_o |-> (icache_req_valid_i && icache_req_rdy_o))
    else begin
      $error("icache answer without request acceptance");
      fail_cnt++;
    end

  // L2 request held steady until taken
  l2c_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (l2c_req_valid_o && !l2c_req_rdy_i) |=> (l2c_req_valid_o && $stable(l2c_req_o)))
    else begin
      $error("L2 request dropped or changed before ready");
      fail_cnt++;
    end

  // No acceptance while a flush is on the bus
  no_rdy_in_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (flush_i.ftype != itlb_pkg::NoFlush) |-> !icache_req_rdy_o)
    else begin
      $error("icache ready high during a flush cycle");
      fail_cnt++;
    end

endmodule

bind itlb tb_itlb_chk i_itlb_chk (
  .clk_i              (clk_i),
  .arst_n_i           (arst_n_i),
  .flush_i            (flush_i),
  .icache_req_valid_i (icache_req_valid_i),
  .icache_req_rdy_o   (icache_req_rdy_o),
  .icache_ans_valid_o (icache_ans_valid_o),
  .l2c_req_valid_o    (l2c_req_valid_o),
  .l2c_req_o          (l2c_req_o),
  .l2c_req_rdy_i      (l2c_req_rdy_i)
);

/* tb_itlb_mon.sv */
`timescale 1ns/1ps
`include "itlb_params.svh"

module tb_itlb_mon (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  vmem_on_i,
  input vm_pkg::asid_t         cur_asid_i,
  input itlb_pkg::flush_req_t  flush_i,
  input itlb_pkg::icache_req_t icache_req_i,
  input logic                  icache_ans_valid_o,
  input itlb_pkg::icache_ans_t icache_ans_o,
  input logic                  l2c_req_valid_o,
  input itlb_pkg::l2c_req_t    l2c_req_o,
  input logic                  l2c_req_rdy_i,
  input logic                  l2c_ans_valid_i
);

  localparam int N = `ITLB_ENTRIES;
  localparam int VW = $bits(vm_pkg::vpn_t);

  // Reference entry array and miss tracking
  vm_pkg::tlb_entry_t model [N];
  int                 rr;
  logic               pend_fault;
  logic               outstanding;
  logic [VW-1:0]      out_vpn;
  vm_pkg::asid_t      out_asid;
  int                 err_count = 0;
  int                 check_count = 0;

  // Page match at the entry's size
  function automatic logic page_match(logic [VW-1:0] ev, logic [VW-1:0] v,
                                      vm_pkg::page_size_e sz);
    if (sz == vm_pkg::page_1g) return ev[26:18] == v[26:18];
    if (sz == vm_pkg::page_2m) return ev[26:9] == v[26:9];
    return ev == v;
  endfunction

  // Lookup in the reference array where the last match wins
  task automatic find_entry(input logic [VW-1:0] v, input vm_pkg::asid_t a,
                            output logic hit, output vm_pkg::ppn_t ppn,
                            output logic exec);
    hit  = 1'b0;
    ppn  = '0;
    exec = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (model[k].valid && page_match(model[k].vpn, v, model[k].size)
          && (model[k].glob || model[k].asid == a)) begin
        hit  = 1'b1;
        exec = model[k].exec;
        ppn  = model[k].ppn;
        // Superpage offset levels come from the VPN
        if (model[k].size == vm_pkg::page_1g) ppn[17:0] = v[17:0];
        if (model[k].size == vm_pkg::page_2m) ppn[8:0] = v[8:0];
      end
    end
  endtask

  // Install as the L2 rule gives it
  task automatic install_entry(input logic [VW-1:0] v, input vm_pkg::asid_t a);
    int victim;
    victim = rr;
    for (int k = N - 1; k >= 0; k--) begin
      if (!model[k].valid) victim = k;
    end
    model[victim].valid = 1'b1;
    model[victim].vpn   = v;
    model[victim].ppn   = vm_pkg::ppn_t'(v) * 44'd3 + vm_pkg::ppn_t'(a);
    model[victim].asid  = a;
    model[victim].glob  = v[3];
    model[victim].exec  = !v[4];
    model[victim].size  = (v[1:0] == 2'd0) ? vm_pkg::page_1g :
                          (v[1:0] == 2'd1) ? vm_pkg::page_2m : vm_pkg::page_4k;
    rr = (rr + 1) % N;
  endtask

  task automatic apply_flush();
    for (int k = 0; k < N; k++) begin
      case (flush_i.ftype)
        itlb_pkg::FlushAll: model[k].valid = 1'b0;
        itlb_pkg::FlushASID:
          if (!model[k].glob && model[k].asid == flush_i.opnd.as_asid.asid)
            model[k].valid = 1'b0;
        itlb_pkg::FlushPage:
          if (page_match(model[k].vpn, flush_i.opnd.as_vpn, model[k].size))
            model[k].valid = 1'b0;
        default: ;
      endcase
    end
  endtask

  // Sample mid-cycle and then apply what the next edge does
  always @(negedge clk_i or negedge arst_n_i) begin
    logic                 hit;
    logic                 exec;
    vm_pkg::ppn_t         exp_ppn;
    itlb_pkg::exception_e exp_exc;
    if (!arst_n_i) begin
      for (int k = 0; k < N; k++) model[k] = '0;
      rr          = 0;
      pend_fault  = 1'b0;
      outstanding = 1'b0;
    end else begin
      if (icache_ans_valid_o) begin
        check_count++;
        find_entry(icache_req_i.vpn, cur_asid_i, hit, exp_ppn, exec);
        exp_exc = itlb_pkg::NoException;
        if (pend_fault) begin
          exp_ppn    = '0;
          exp_exc    = itlb_pkg::InstrPageFault;
          pend_fault = 1'b0;
        end else if (!vmem_on_i) begin
          exp_ppn = vm_pkg::ppn_t'(icache_req_i.vpn);
        end else if (!hit) begin
          $display("answer for vpn 0x%h given, but the model holds no entry for it",
                   icache_req_i.vpn);
          err_count++;
        end else if (!exec) begin
          exp_exc = itlb_pkg::InstrPageFault;
        end
        if (icache_ans_o.ppn !== exp_ppn) begin
          $display("FAILED icache_ans_o.ppn: expected 0x%h, got 0x%h (vpn 0x%h)",
                   exp_ppn, icache_ans_o.ppn, icache_req_i.vpn);
          err_count++;
        end
        if (icache_ans_o.exception !== exp_exc) begin
          $display("FAILED icache_ans_o.exception: expected 0x%h, got 0x%h (vpn 0x%h)",
                   exp_exc, icache_ans_o.exception, icache_req_i.vpn);
          err_count++;
        end
      end
      if (l2c_req_valid_o && l2c_req_rdy_i) begin
        check_count++;
        find_entry(icache_req_i.vpn, cur_asid_i, hit, exp_ppn, exec);
        if (!vmem_on_i || hit) begin
          $display("L2 request for vpn 0x%h where the model expects a hit", icache_req_i.vpn);
          err_count++;
        end
        if (l2c_req_o.vpn !== icache_req_i.vpn) begin
          $display("FAILED l2c_req_o.vpn: expected 0x%h, got 0x%h",
                   icache_req_i.vpn, l2c_req_o.vpn);
          err_count++;
        end
        if (l2c_req_o.asid !== cur_asid_i) begin
          $display("FAILED l2c_req_o.asid: expected 0x%h, got 0x%h",
                   cur_asid_i, l2c_req_o.asid);
          err_count++;
        end
        outstanding = 1'b1;
        out_vpn     = icache_req_i.vpn;
        out_asid    = cur_asid_i;
      end
      if (flush_i.ftype != itlb_pkg::NoFlush) apply_flush();
      // Fill lands after the flush of the same edge
      if (l2c_ans_valid_i && outstanding) begin
        outstanding = 1'b0;
        if (out_vpn % 13 == 0) pend_fault = 1'b1;
        else if (vmem_on_i) install_entry(out_vpn, out_asid);
      end
    end
  end

endmodule

/* vm_pkg.sv */
`include "itlb_params.svh"

package vm_pkg;

  // One level of the virtual page number
  typedef logic [`ITLB_VPN_LVL_W-1:0] vpn_lvl_t;

  // Three levels, index 2 is the top level
  typedef vpn_lvl_t [2:0] vpn_t;

  typedef logic [`ITLB_PPN_W-1:0] ppn_t;

  typedef logic [`ITLB_ASID_W-1:0] asid_t;

  // Leaf page sizes
  typedef enum logic [1:0] {
    page_4k,
    page_2m,
    page_1g
  } page_size_e;

  // One TLB entry
  typedef struct packed {
    logic       valid;
    vpn_t       vpn;
    ppn_t       ppn;
    asid_t      asid;
    logic       glob;
    page_size_e size;
    logic       exec;
  } tlb_entry_t;

  // Page match at the page's own size
  // 1 GiB compares the top level, 2 MiB the upper two, 4 KiB all three
  function automatic logic vpn_covers(vpn_t page_vpn, vpn_t vpn, page_size_e size);
    case (size)
      page_1g: return page_vpn[2] == vpn[2];
      page_2m: return page_vpn[2:1] == vpn[2:1];
      default: return page_vpn == vpn;
    endcase
  endfunction

endpackage
